// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = spmm_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failed
PASS_MSG = Test completed successfully

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/spmm_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module spmm_assertions (
  input logic clk,
  input logic rst_n,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic busy_i,
  input logic done_i,
  input logic result_we_i
);

  int fail_count = 0;

  // ack answers the request of the cycle before
  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |-> $past(cyc_i && stb_i))
    else begin
      $error("ack without a request in the previous cycle");
      fail_count++;
    end

  done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> $past(busy_i))
    else begin
      $error("done pulse without a run in the previous cycle");
      fail_count++;
    end

  result_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
    result_we_i |-> busy_i)
    else begin
      $error("result write while the engine is idle");
      fail_count++;
    end

endmodule

bind spmm_top spmm_assertions u_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .cyc_i       (wb_cyc_i),
  .stb_i       (wb_stb_i),
  .ack_i       (wb_ack_o),
  .busy_i      (busy),
  .done_i      (done),
  .result_we_i (result_we)
);

`default_nettype wire

// ==== sim/spmm_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module spmm_tb;
  import spmm_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_COLS        = 4;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int ACK_LIMIT       = 8;
  localparam int POLL_LIMIT      = CYCLES_PER_TEST / 3;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [11:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  integer seed = 32'h9dad_d880;
  int check_count = 0;
  int error_count = 0;
  int checks_before = 0;
  int errors_before = 0;

  // host copies of the memory contents
  int row_len [32];
  int row_tag [32];
  int row_flag [32];
  int nz_col [128];
  int nz_val [128];
  int weight [64][NUM_COLS];

  spmm_top #(.NUM_COLS(NUM_COLS)) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // expected sum of value times weight over one row
  function automatic int ref_acc(input int row, input int col);
    int base;
    int sum;
    base = 0;
    sum  = 0;
    for (int r = 0; r < row; r++) begin
      base += row_len[r];
    end
    for (int i = 0; i < row_len[row]; i++) begin
      sum += nz_val[base + i] * weight[nz_col[base + i]][col];
    end
    return sum;
  endfunction

  function automatic logic [31:0] weight_word(input int r);
    logic [31:0] word;
    word = '0;
    for (int c = 0; c < NUM_COLS; c++) begin
      word[c*8 +: 8] = 8'(weight[r][c]);
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %s, %0d checks", num, name,
             (error_count == errors_before) ? "ok" : "FAILED", check_count - checks_before);
    checks_before = check_count;
    errors_before = error_count;
  endtask

  // strobe drops on the falling edge that sees ack
  task automatic wb_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                          output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (!wb_ack) begin
      $display("no Wishbone ack for access to address 0x%03h", adr);
      error_count++;
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [11:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [11:0] adr, output logic [31:0] dat);
    wb_cycle(1'b0, adr, 32'h0, dat);
  endtask

  task automatic make_random_weights();
    for (int r = 0; r < 64; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        weight[r][c] = rand_range(-128, 127);
      end
    end
  endtask

  task automatic make_random_matrix(input int nrows, input int max_len);
    int base;
    base = 0;
    for (int r = 0; r < nrows; r++) begin
      row_len[r]  = rand_range(1, max_len);
      row_tag[r]  = rand_range(0, 255);
      row_flag[r] = rand_range(0, 1);
      for (int i = 0; i < row_len[r]; i++) begin
        nz_col[base + i] = rand_range(0, 63);
        nz_val[base + i] = rand_range(-128, 127);
      end
      base += row_len[r];
    end
  endtask

  task automatic load_weights();
    for (int r = 0; r < 64; r++) begin
      wb_write(WIN_WEIGHT + 12'(r * 4), weight_word(r));
    end
  endtask

  // info word is {length, tag, flag}, a nonzero is {column, value}
  task automatic load_matrix(input int nrows);
    int base;
    base = 0;
    for (int r = 0; r < nrows; r++) begin
      wb_write(WIN_INFO + 12'(r * 4),
               {16'h0, 7'(row_len[r]), 8'(row_tag[r]), 1'(row_flag[r])});
      for (int i = 0; i < row_len[r]; i++) begin
        wb_write(WIN_NNZ + 12'((base + i) * 4),
                 {18'h0, 6'(nz_col[base + i]), 8'(nz_val[base + i])});
      end
      base += row_len[r];
    end
    wb_write(ADR_NUM_ROWS, 32'(nrows));
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < POLL_LIMIT) begin
      wb_read(ADR_STATUS, status);
      polls++;
    end
    if (!status[1]) begin
      $display("run never finished, done bit still clear after %0d status reads", polls);
      error_count++;
    end
  endtask

  task automatic check_results(input int nrows);
    logic [31:0] got;
    for (int r = 0; r < nrows; r++) begin
      for (int k = 0; k < NUM_COLS; k++) begin
        wb_read(WIN_RESULT + 12'(r * 32 + k * 4), got);
        check_value($sformatf("row %0d col %0d", r, k), ref_acc(r, k), got);
      end
    end
  endtask

  task automatic check_tags(input int nrows);
    logic [31:0] got;
    for (int r = 0; r < nrows; r++) begin
      wb_read(WIN_RESULT + 12'(r * 32 + 16), got);
      check_value($sformatf("row %0d tag and flag", r),
                  {23'h0, 1'(row_flag[r]), 8'(row_tag[r])}, got);
    end
  endtask

  initial begin : watchdog
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * CYCLES_PER_TEST);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    logic [31:0] data;
    logic [31:0] old_word;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    wb_read(ADR_STATUS, data);
    check_value("status after reset", 32'h0, data);
    wb_write(ADR_NUM_ROWS, 32'd21);
    wb_read(ADR_NUM_ROWS, data);
    check_value("num_rows readback", 32'd21, data);
    wb_read(12'h0fc, data);
    check_value("unmapped read", 32'h0, data);
    end_test(1, "register access");

    // one nonzero per row picks out a scaled row of W
    make_random_weights();
    load_weights();
    row_len[0] = 1;
    row_tag[0] = 8'h11;
    row_flag[0] = 1;
    nz_col[0] = 5;
    nz_val[0] = 3;
    row_len[1] = 1;
    row_tag[1] = 8'h22;
    row_flag[1] = 0;
    nz_col[1] = 9;
    nz_val[1] = -2;
    load_matrix(2);
    wb_write(ADR_CTRL, 32'h1);
    wait_done();
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < NUM_COLS; k++) begin
        wb_read(WIN_RESULT + 12'(r * 32 + k * 4), data);
        check_value($sformatf("scaled row %0d col %0d", r, k),
                    nz_val[r] * weight[nz_col[r]][k], data);
      end
    end
    end_test(2, "single nonzero rows");

    make_random_weights();
    load_weights();
    make_random_matrix(12, 8);
    load_matrix(12);
    wb_write(ADR_CTRL, 32'h1);
    wait_done();
    check_results(12);
    end_test(3, "random sparse matrix");

    check_tags(12);
    end_test(4, "tag and flag");

    old_word = weight_word(0);
    wb_write(ADR_CTRL, 32'h1);
    wb_read(ADR_STATUS, data);
    check_value("status while running", 32'h1, data);
    wb_write(WIN_WEIGHT, ~old_word);
    wait_done();
    wb_read(ADR_STATUS, data);
    check_value("status after run", 32'h2, data);
    wb_read(WIN_WEIGHT, data);
    check_value("weight row 0 after write while busy", old_word, data);
    end_test(5, "busy and done");

    make_random_weights();
    load_weights();
    make_random_matrix(7, 8);
    load_matrix(7);
    wb_write(ADR_CTRL, 32'h1);
    wb_read(ADR_STATUS, data);
    check_value("done cleared by second start", 32'h1, data);
    wait_done();
    wb_read(ADR_STATUS, data);
    check_value("done set after second run", 32'h2, data);
    check_results(7);
    check_tags(7);
    end_test(6, "back-to-back runs");

    // failures of the bound protocol checker
    error_count += UUT.u_assertions.fail_count;
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/spmm_pkg.sv
verilog/spmm_ram.sv
verilog/spmm_csr.sv
verilog/spmm_pe.sv
verilog/spmm_engine.sv
verilog/spmm_top.sv
sim/spmm_assertions.sv
sim/spmm_tb.sv

// ==== verilog/spmm_csr.sv ====
`timescale 1ns/100ps
`default_nettype none

module spmm_csr #(
  parameter int NUM_COLS = spmm_pkg::NUM_COLS_DEF
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        wb_cyc_i,
  input  logic                                        wb_stb_i,
  input  logic                                        wb_we_i,
  input  logic [spmm_pkg::WB_ADR_W-1:0]               wb_adr_i,
  input  logic [spmm_pkg::WB_DAT_W-1:0]               wb_dat_i,
  output logic [spmm_pkg::WB_DAT_W-1:0]               wb_dat_o,
  output logic                                        wb_ack_o,
  output logic                                        start_o,
  output logic [spmm_pkg::NUM_ROWS_W-1:0]             num_rows_o,
  input  logic                                        busy_i,
  input  logic                                        done_i,
  output logic                                        info_we_o,
  output logic                                        nnz_we_o,
  output logic                                        weight_we_o,
  output logic [spmm_pkg::HOST_ADDR_W-1:0]            host_wr_addr_o,
  output logic [spmm_pkg::WB_DAT_W-1:0]               host_wr_data_o,
  output logic [spmm_pkg::HOST_ADDR_W-1:0]            host_rd_addr_o,
  input  logic [spmm_pkg::NODE_INFO_W-1:0]            info_rd_i,
  input  logic [spmm_pkg::NNZ_W-1:0]                  nnz_rd_i,
  input  logic [NUM_COLS*spmm_pkg::VAL_W-1:0]         weight_rd_i,
  input  logic [NUM_COLS*spmm_pkg::ACC_W+spmm_pkg::TAG_W:0] result_rd_i
);
  import spmm_pkg::*;

  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_STATUS,
    SEL_ROWS,
    SEL_INFO,
    SEL_NNZ,
    SEL_WEIGHT,
    SEL_RESULT
  } rd_sel_e;

  logic                     req;
  logic                     wr_req;
  logic                     hit_info;
  logic                     hit_nnz;
  logic                     hit_weight;
  logic                     hit_result;
  logic                     done_q;
  rd_sel_e                  sel_d;
  rd_sel_e                  sel_q;
  logic [RESULT_WORD_W-1:0] word_q;

  // a held strobe is not answered twice
  assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_req = req && wb_we_i;

  assign hit_info   = wb_adr_i[WB_ADR_W-1:ROW_ADDR_W+2] == WIN_INFO[WB_ADR_W-1:ROW_ADDR_W+2];
  assign hit_nnz    = wb_adr_i[WB_ADR_W-1:NNZ_ADDR_W+2] == WIN_NNZ[WB_ADR_W-1:NNZ_ADDR_W+2];
  assign hit_weight = wb_adr_i[WB_ADR_W-1:COL_IDX_W+2] == WIN_WEIGHT[WB_ADR_W-1:COL_IDX_W+2];
  assign hit_result = wb_adr_i[WB_ADR_W-1:ROW_ADDR_W+RESULT_WORD_W+2] ==
                      WIN_RESULT[WB_ADR_W-1:ROW_ADDR_W+RESULT_WORD_W+2];

  // memories only take host writes while idle
  assign info_we_o      = wr_req && hit_info && !busy_i;
  assign nnz_we_o       = wr_req && hit_nnz && !busy_i;
  assign weight_we_o    = wr_req && hit_weight && !busy_i;
  assign host_wr_addr_o = wb_adr_i[WB_ADR_W-1:2];
  assign host_wr_data_o = wb_dat_i;
  assign host_rd_addr_o = wb_adr_i[WB_ADR_W-1:2];

  always_comb begin
    if (wb_adr_i == ADR_STATUS) sel_d = SEL_STATUS;
    else if (wb_adr_i == ADR_NUM_ROWS) sel_d = SEL_ROWS;
    else if (hit_info) sel_d = SEL_INFO;
    else if (hit_nnz) sel_d = SEL_NNZ;
    else if (hit_weight) sel_d = SEL_WEIGHT;
    else if (hit_result) sel_d = SEL_RESULT;
    else sel_d = SEL_NONE;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack_o   <= 1'b0;
      start_o    <= 1'b0;
      num_rows_o <= '0;
      done_q     <= 1'b0;
      sel_q      <= SEL_NONE;
    end else begin
      wb_ack_o <= req;
      start_o  <= wr_req && (wb_adr_i == ADR_CTRL) && wb_dat_i[0] && !busy_i;
      if (wr_req && (wb_adr_i == ADR_NUM_ROWS)) begin
        num_rows_o <= wb_dat_i[NUM_ROWS_W-1:0];
      end
      // sticky until the next run starts
      if (start_o) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;
      end
      if (req) begin
        sel_q <= sel_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      word_q <= wb_adr_i[RESULT_WORD_W+1:2];
    end
  end

  always_comb begin
    wb_dat_o = '0;
    case (sel_q)
      SEL_STATUS: wb_dat_o = WB_DAT_W'({done_q, busy_i});
      SEL_ROWS:   wb_dat_o = WB_DAT_W'(num_rows_o);
      SEL_INFO:   wb_dat_o = WB_DAT_W'(info_rd_i);
      SEL_NNZ:    wb_dat_o = WB_DAT_W'(nnz_rd_i);
      SEL_WEIGHT: wb_dat_o = WB_DAT_W'(weight_rd_i);
      SEL_RESULT: begin
        if (int'(word_q) < NUM_COLS) begin
          wb_dat_o = WB_DAT_W'(signed'(result_rd_i[int'(word_q)*ACC_W +: ACC_W]));
        end else if (int'(word_q) == TAG_WORD) begin
          wb_dat_o = WB_DAT_W'(result_rd_i[NUM_COLS*ACC_W +: TAG_W+1]);
        end
      end
      default:    wb_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/spmm_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module spmm_engine #(
  parameter int NUM_COLS = spmm_pkg::NUM_COLS_DEF
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        start_i,
  input  logic [spmm_pkg::NUM_ROWS_W-1:0]             num_rows_i,
  output logic                                        busy_o,
  output logic                                        done_o,
  output logic [spmm_pkg::ROW_ADDR_W-1:0]             info_rd_addr_o,
  input  logic [spmm_pkg::NODE_INFO_W-1:0]            info_rd_i,
  output logic [spmm_pkg::NNZ_ADDR_W-1:0]             nnz_rd_addr_o,
  input  logic [spmm_pkg::NNZ_W-1:0]                  nnz_rd_i,
  output logic                                        pe_clear_o,
  output logic                                        pe_acc_en_o,
  output logic signed [spmm_pkg::VAL_W-1:0]           pe_value_o,
  input  logic [NUM_COLS*spmm_pkg::ACC_W-1:0]         pe_acc_i,
  output logic                                        result_we_o,
  output logic [spmm_pkg::ROW_ADDR_W-1:0]             result_addr_o,
  output logic [NUM_COLS*spmm_pkg::ACC_W+spmm_pkg::TAG_W:0] result_data_o
);
  import spmm_pkg::*;

  eng_state_e              state_q;
  logic [ROW_ADDR_W-1:0]   row_q;
  logic [NNZ_ADDR_W-1:0]   nnz_addr_q;
  logic [ROW_LEN_W-1:0]    rem_q;
  logic [ROW_LEN_W-1:0]    len_q;
  logic [TAG_W-1:0]        tag_q;
  logic                    flag_q;
  logic                    drain_q;
  logic [ROW_LEN_W-1:0]    info_len;
  logic                    last_row;
  logic                    issue;
  logic                    first_issue;
  logic [1:0]              en_pipe;
  logic [1:0]              clr_pipe;
  logic signed [VAL_W-1:0] value_q;

  assign info_len    = info_rd_i[NODE_INFO_W-1 -: ROW_LEN_W];
  assign last_row    = ({1'b0, row_q} + 1'b1) == num_rows_i;
  assign issue       = state_q == ENG_STREAM;
  assign first_issue = issue && (rem_q == len_q);

  // info address runs one row ahead so the fetch cycle sees valid data
  assign info_rd_addr_o = (state_q == ENG_IDLE) ? '0 : row_q + 1'b1;
  assign nnz_rd_addr_o  = nnz_addr_q;
  assign busy_o         = state_q != ENG_IDLE;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ENG_IDLE;
      row_q      <= '0;
      nnz_addr_q <= '0;
      rem_q      <= '0;
      drain_q    <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        ENG_IDLE: begin
          if (start_i && (num_rows_i != '0)) begin
            state_q    <= ENG_ROW_FETCH;
            row_q      <= '0;
            nnz_addr_q <= '0;
          end
        end
        ENG_ROW_FETCH: begin
          rem_q   <= info_len;
          state_q <= ENG_STREAM;
        end
        ENG_STREAM: begin
          nnz_addr_q <= nnz_addr_q + 1'b1;
          rem_q      <= rem_q - 1'b1;
          if (rem_q == ROW_LEN_W'(1)) begin
            state_q <= ENG_DRAIN;
            drain_q <= 1'b0;
          end
        end
        // wait out the nonzero and weight read latencies
        ENG_DRAIN: begin
          drain_q <= 1'b1;
          if (drain_q) begin
            state_q <= ENG_STORE;
          end
        end
        ENG_STORE: begin
          if (last_row) begin
            state_q <= ENG_IDLE;
            done_o  <= 1'b1;
          end else begin
            row_q   <= row_q + 1'b1;
            state_q <= ENG_ROW_FETCH;
          end
        end
        default: state_q <= ENG_IDLE;
      endcase
    end
  end

  // control follows the data through nonzero ram then weight ram
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_pipe  <= '0;
      clr_pipe <= '0;
    end else begin
      en_pipe  <= {en_pipe[0], issue};
      clr_pipe <= {clr_pipe[0], first_issue};
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ENG_ROW_FETCH) begin
      {len_q, tag_q, flag_q} <= info_rd_i;
    end
    value_q <= nnz_rd_i[VAL_W-1:0];
  end

  assign pe_acc_en_o = en_pipe[1];
  assign pe_clear_o  = clr_pipe[1];
  assign pe_value_o  = value_q;

  assign result_we_o   = state_q == ENG_STORE;
  assign result_addr_o = row_q;
  assign result_data_o = {flag_q, tag_q, pe_acc_i};

endmodule

`default_nettype wire

// ==== verilog/spmm_pe.sv ====
`timescale 1ns/100ps
`default_nettype none

module spmm_pe (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              clear_i,
  input  logic                              acc_en_i,
  input  logic signed [spmm_pkg::VAL_W-1:0] value_i,
  input  logic signed [spmm_pkg::VAL_W-1:0] weight_i,
  output logic signed [spmm_pkg::ACC_W-1:0] acc_o
);
  import spmm_pkg::*;

  logic signed [2*VAL_W-1:0] product;
  logic signed [ACC_W-1:0]   acc_base;

  assign product = value_i * weight_i;

  // first product of a row replaces the old sum
  assign acc_base = clear_i ? '0 : acc_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_o <= '0;
    end else if (acc_en_i) begin
      acc_o <= acc_base + ACC_W'(product);
    end else if (clear_i) begin
      acc_o <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spmm_pkg.sv ====
`default_nettype none

package spmm_pkg;

  // array size
  localparam int NUM_COLS_DEF = 4;

  // datapath widths
  localparam int VAL_W      = 8;
  localparam int ACC_W      = 20;
  localparam int COL_IDX_W  = 6;
  localparam int NNZ_ADDR_W = 7;
  localparam int ROW_ADDR_W = 5;
  localparam int ROW_LEN_W  = 7;
  localparam int TAG_W      = 8;

  // node info is {length, tag, flag}, a nonzero is {column, value}
  localparam int NODE_INFO_W = ROW_LEN_W + TAG_W + 1;
  localparam int NNZ_W       = COL_IDX_W + VAL_W;
  localparam int NUM_ROWS_W  = ROW_ADDR_W + 1;

  // wishbone side
  localparam int WB_ADR_W    = 12;
  localparam int WB_DAT_W    = 32;
  localparam int HOST_ADDR_W = WB_ADR_W - 2;

  localparam logic [WB_ADR_W-1:0] ADR_CTRL     = 12'h000;
  localparam logic [WB_ADR_W-1:0] ADR_STATUS   = 12'h004;
  localparam logic [WB_ADR_W-1:0] ADR_NUM_ROWS = 12'h008;
  localparam logic [WB_ADR_W-1:0] WIN_INFO     = 12'h100;
  localparam logic [WB_ADR_W-1:0] WIN_NNZ      = 12'h200;
  localparam logic [WB_ADR_W-1:0] WIN_WEIGHT   = 12'h400;
  localparam logic [WB_ADR_W-1:0] WIN_RESULT   = 12'h800;

  // eight words per result row, tag and flag in word 4
  localparam int RESULT_WORD_W = 3;
  localparam int TAG_WORD      = 4;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_ROW_FETCH,
    ENG_STREAM,
    ENG_DRAIN,
    ENG_STORE
  } eng_state_e;

endpackage

`default_nettype wire

// ==== verilog/spmm_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module spmm_ram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  logic [WIDTH-1:0]         wr_data_i,
  input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
  output logic [WIDTH-1:0]         rd_data_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

`default_nettype wire

// ==== verilog/spmm_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module spmm_top #(
  parameter int NUM_COLS = spmm_pkg::NUM_COLS_DEF
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [spmm_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [spmm_pkg::WB_DAT_W-1:0] wb_dat_i,
  output logic [spmm_pkg::WB_DAT_W-1:0] wb_dat_o,
  output logic                          wb_ack_o
);
  import spmm_pkg::*;

  localparam int WEIGHT_W = NUM_COLS * VAL_W;
  localparam int RESULT_W = NUM_COLS * ACC_W + TAG_W + 1;

  logic                      start;
  logic [NUM_ROWS_W-1:0]     num_rows;
  logic                      busy;
  logic                      done;
  logic                      eng_sel;
  logic                      info_we;
  logic                      nnz_we;
  logic                      weight_we;
  logic [HOST_ADDR_W-1:0]    host_wr_addr;
  logic [WB_DAT_W-1:0]       host_wr_data;
  logic [HOST_ADDR_W-1:0]    host_rd_addr;
  logic [ROW_ADDR_W-1:0]     eng_info_addr;
  logic [NNZ_ADDR_W-1:0]     eng_nnz_addr;
  logic [ROW_ADDR_W-1:0]     info_addr;
  logic [NNZ_ADDR_W-1:0]     nnz_addr;
  logic [COL_IDX_W-1:0]      weight_addr;
  logic [NODE_INFO_W-1:0]    info_rd;
  logic [NNZ_W-1:0]          nnz_rd;
  logic [WEIGHT_W-1:0]       weight_rd;
  logic [RESULT_W-1:0]       result_rd;
  logic                      pe_clear;
  logic                      pe_acc_en;
  logic signed [VAL_W-1:0]   pe_value;
  logic [NUM_COLS*ACC_W-1:0] pe_acc;
  logic                      result_we;
  logic [ROW_ADDR_W-1:0]     result_addr;
  logic [RESULT_W-1:0]       result_data;

  // engine owns the read ports from start until the run ends
  assign eng_sel     = busy || start;
  assign info_addr   = eng_sel ? eng_info_addr : host_rd_addr[ROW_ADDR_W-1:0];
  assign nnz_addr    = eng_sel ? eng_nnz_addr : host_rd_addr[NNZ_ADDR_W-1:0];
  assign weight_addr = eng_sel ? nnz_rd[NNZ_W-1:VAL_W] : host_rd_addr[COL_IDX_W-1:0];

  spmm_csr #(.NUM_COLS(NUM_COLS)) u_csr (
    .clk, .rst_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .start_o(start), .num_rows_o(num_rows), .busy_i(busy), .done_i(done),
    .info_we_o(info_we), .nnz_we_o(nnz_we), .weight_we_o(weight_we),
    .host_wr_addr_o(host_wr_addr), .host_wr_data_o(host_wr_data),
    .host_rd_addr_o(host_rd_addr), .info_rd_i(info_rd), .nnz_rd_i(nnz_rd),
    .weight_rd_i(weight_rd), .result_rd_i(result_rd)
  );

  spmm_engine #(.NUM_COLS(NUM_COLS)) u_engine (
    .clk, .rst_n, .start_i(start), .num_rows_i(num_rows), .busy_o(busy), .done_o(done),
    .info_rd_addr_o(eng_info_addr), .info_rd_i(info_rd),
    .nnz_rd_addr_o(eng_nnz_addr), .nnz_rd_i(nnz_rd),
    .pe_clear_o(pe_clear), .pe_acc_en_o(pe_acc_en), .pe_value_o(pe_value), .pe_acc_i(pe_acc),
    .result_we_o(result_we), .result_addr_o(result_addr), .result_data_o(result_data)
  );

  spmm_ram #(.WIDTH(NODE_INFO_W), .DEPTH(1 << ROW_ADDR_W)) u_info_ram (
    .clk, .we_i(info_we), .wr_addr_i(host_wr_addr[ROW_ADDR_W-1:0]),
    .wr_data_i(host_wr_data[NODE_INFO_W-1:0]), .rd_addr_i(info_addr), .rd_data_o(info_rd)
  );

  spmm_ram #(.WIDTH(NNZ_W), .DEPTH(1 << NNZ_ADDR_W)) u_nnz_ram (
    .clk, .we_i(nnz_we), .wr_addr_i(host_wr_addr[NNZ_ADDR_W-1:0]),
    .wr_data_i(host_wr_data[NNZ_W-1:0]), .rd_addr_i(nnz_addr), .rd_data_o(nnz_rd)
  );

  spmm_ram #(.WIDTH(WEIGHT_W), .DEPTH(1 << COL_IDX_W)) u_weight_ram (
    .clk, .we_i(weight_we), .wr_addr_i(host_wr_addr[COL_IDX_W-1:0]),
    .wr_data_i(host_wr_data[WEIGHT_W-1:0]), .rd_addr_i(weight_addr), .rd_data_o(weight_rd)
  );

  spmm_ram #(.WIDTH(RESULT_W), .DEPTH(1 << ROW_ADDR_W)) u_result_ram (
    .clk, .we_i(result_we), .wr_addr_i(result_addr), .wr_data_i(result_data),
    .rd_addr_i(host_rd_addr[ROW_ADDR_W+RESULT_WORD_W-1:RESULT_WORD_W]), .rd_data_o(result_rd)
  );

  // one column of W per element
  for (genvar c = 0; c < NUM_COLS; c++) begin : g_pe
    spmm_pe u_pe (
      .clk,
      .rst_n,
      .clear_i  (pe_clear),
      .acc_en_i (pe_acc_en),
      .value_i  (pe_value),
      .weight_i (weight_rd[c*VAL_W +: VAL_W]),
      .acc_o    (pe_acc[c*ACC_W +: ACC_W])
    );
  end

endmodule

`default_nettype wire
